//--- hw/tag_pkg.sv
`default_nettype none

package tag_pkg;

  //////////////////////////////////////////////////
  // Widths and counts

  localparam int unsigned client_id_width_lp = 4;
  localparam int unsigned did_width_lp       = 7;
  localparam int unsigned payload_width_lp   = did_width_lp + 1;
  localparam int unsigned packet_bits_lp     = 1 + client_id_width_lp + payload_width_lp;
  localparam int unsigned rom_addr_width_lp  = 5;
  localparam int unsigned rom_depth_lp       = 32;
  localparam int unsigned num_clients_lp     = 3;
  localparam int unsigned bit_cnt_width_lp   = $clog2(packet_bits_lp + 1);

  typedef logic [client_id_width_lp-1:0] client_id_t;
  typedef logic [rom_addr_width_lp-1:0]  rom_addr_t;
  typedef logic [bit_cnt_width_lp-1:0]   bit_cnt_t;
  typedef logic [payload_width_lp-1:0]   wait_cnt_t;

  localparam rom_addr_t rom_last_addr_lp = rom_addr_t'(rom_depth_lp - 1);

  // Serial line counts, start bit included and excluded
  localparam bit_cnt_t packet_cnt_lp = bit_cnt_t'(packet_bits_lp);
  localparam bit_cnt_t body_cnt_lp   = bit_cnt_t'(packet_bits_lp - 1);

  //////////////////////////////////////////////////
  // Client ids

  localparam client_id_t client_core_lp   = 4'd9;
  localparam client_id_t client_host_lp   = 4'd10;
  localparam client_id_t client_router_lp = 4'd11;

  // Index 0 is core, 1 is host, 2 is router
  localparam logic [num_clients_lp-1:0][client_id_width_lp-1:0] client_ids_lp =
    {client_router_lp, client_host_lp, client_core_lp};

  //////////////////////////////////////////////////
  // Types

  typedef enum logic [1:0]
  {
    e_op_nop  = 2'd0
   ,e_op_send = 2'd1
   ,e_op_wait = 2'd2
   ,e_op_done = 2'd3
  } tag_op_e;

  typedef struct packed
  {
    logic                    reset;
    logic [did_width_lp-1:0] did;
  } tag_payload_s;

  typedef struct packed
  {
    client_id_t   id;
    tag_payload_s payload;
  } tag_packet_s;

  // Payload doubles as the cycle count of a wait word
  typedef struct packed
  {
    tag_op_e      op;
    client_id_t   id;
    tag_payload_s payload;
  } tag_trace_word_s;

endpackage

`default_nettype wire

//--- hw/tag_trace_rom.sv
`default_nettype none

module tag_trace_rom
  (input  logic                                 clk_i
  ,input  logic [tag_pkg::rom_addr_width_lp-1:0] addr_i
  ,output tag_pkg::tag_trace_word_s              data_o
  );

  tag_pkg::tag_trace_word_s mem [tag_pkg::rom_depth_lp];

  // Entries past the end of the trace file read back as nop
  initial
    begin
      for (int i = 0; i < tag_pkg::rom_depth_lp; i++)
        begin
          mem[i] = '0;
        end
      $readmemh("hw/tag_trace.mem", mem);
    end

  // Registered read
  always_ff @(posedge clk_i)
    begin
      data_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- hw/tag_trace_replay.sv
`default_nettype none

module tag_trace_replay
  (input  logic                                 clk_i
  ,input  logic                                 rst_n_i
  ,input  logic                                 enable_i
  ,output logic [tag_pkg::rom_addr_width_lp-1:0] rom_addr_o
  ,input  tag_pkg::tag_trace_word_s              rom_data_i
  ,input  logic                                 busy_i
  ,output logic                                 send_v_o
  ,output tag_pkg::tag_packet_s                  send_o
  ,output logic                                 done_o
  );

  typedef enum logic [1:0]
  {
    e_fetch
   ,e_decode
   ,e_wait
   ,e_done
  } state_e;

  state_e                state_r;
  tag_pkg::rom_addr_t    addr_r;
  tag_pkg::wait_cnt_t    wait_cnt_r;
  logic                  send_v_r;
  logic                  done_r;
  tag_pkg::tag_packet_s  send_r;

  logic advance;
  logic issue;
  logic stop;
  logic last_word;

  assign last_word = (addr_r == tag_pkg::rom_last_addr_lp);

  //////////////////////////////////////////////////
  // Opcode decode

  always_comb
    begin
      advance = 1'b0;
      issue   = 1'b0;
      stop    = 1'b0;
      case (state_r)
        e_decode:
          if (enable_i)
            begin
              case (rom_data_i.op)
                tag_pkg::e_op_nop:  advance = 1'b1;
                tag_pkg::e_op_send:
                  begin
                    // Hold the word until the serializer is free
                    issue   = ~busy_i;
                    advance = ~busy_i;
                  end
                tag_pkg::e_op_wait: advance = (rom_data_i.payload == '0);
                tag_pkg::e_op_done: stop    = 1'b1;
                default:            advance = 1'b1;
              endcase
            end
        e_wait:
          advance = enable_i & (wait_cnt_r == tag_pkg::wait_cnt_t'(1));
        default:
          advance = 1'b0;
      endcase

      // Running off the end of the table also ends the trace
      if (advance && last_word)
        begin
          stop = 1'b1;
        end
    end

  //////////////////////////////////////////////////
  // Sequencing

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          state_r    <= e_fetch;
          addr_r     <= '0;
          wait_cnt_r <= '0;
          send_v_r   <= 1'b0;
          done_r     <= 1'b0;
        end
      else
        begin
          send_v_r <= issue;
          if (stop)
            begin
              state_r <= e_done;
              done_r  <= 1'b1;
            end
          else if (advance)
            begin
              addr_r  <= addr_r + 1'b1;
              state_r <= e_fetch;
            end
          else
            begin
              case (state_r)
                e_fetch:
                  if (enable_i)
                    begin
                      state_r <= e_decode;
                    end
                e_decode:
                  if (enable_i && rom_data_i.op == tag_pkg::e_op_wait)
                    begin
                      wait_cnt_r <= rom_data_i.payload;
                      state_r    <= e_wait;
                    end
                e_wait:
                  if (enable_i)
                    begin
                      wait_cnt_r <= wait_cnt_r - 1'b1;
                    end
                default:
                  state_r <= e_done;
              endcase
            end
        end
    end

  // Packet captured with the strobe
  always_ff @(posedge clk_i)
    begin
      if (issue)
        begin
          send_r.id      <= rom_data_i.id;
          send_r.payload <= rom_data_i.payload;
        end
    end

  assign rom_addr_o = addr_r;
  assign send_v_o   = send_v_r;
  assign send_o     = send_r;
  assign done_o     = done_r;

endmodule

`default_nettype wire

//--- hw/tag_serializer.sv
`default_nettype none

module tag_serializer
  (input  logic                 clk_i
  ,input  logic                 rst_n_i
  ,input  logic                 send_v_i
  ,input  tag_pkg::tag_packet_s send_i
  ,output logic                 busy_o
  ,output logic                 tag_data_o
  );

  logic [tag_pkg::packet_bits_lp-1:0] shift_r;
  tag_pkg::bit_cnt_t                  cnt_r;
  logic                               active_r;

  // Bit counter, one count per bit left on the line
  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          active_r <= 1'b0;
          cnt_r    <= '0;
        end
      else if (send_v_i)
        begin
          active_r <= 1'b1;
          cnt_r    <= tag_pkg::packet_cnt_lp;
        end
      else if (active_r)
        begin
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == tag_pkg::bit_cnt_t'(1))
            begin
              active_r <= 1'b0;
            end
        end
    end

  // Start bit leads, then id and payload MSB first
  always_ff @(posedge clk_i)
    begin
      if (send_v_i)
        begin
          shift_r <= {1'b1, send_i};
        end
      else if (active_r)
        begin
          shift_r <= {shift_r[tag_pkg::packet_bits_lp-2:0], 1'b0};
        end
    end

  assign busy_o     = active_r | send_v_i;

  // Line idles low
  assign tag_data_o = active_r & shift_r[tag_pkg::packet_bits_lp-1];

endmodule

`default_nettype wire

//--- hw/tag_master.sv
`default_nettype none

module tag_master
  (input  logic                 clk_i
  ,input  logic                 rst_n_i
  ,input  logic                 tag_data_i
  ,output logic                 update_v_o
  ,output tag_pkg::tag_packet_s update_o
  );

  typedef enum logic
  {
    e_idle
   ,e_recv
  } state_e;

  state_e                                 state_r;
  tag_pkg::bit_cnt_t                      cnt_r;
  logic [$bits(tag_pkg::tag_packet_s)-1:0] shift_r;
  logic                                   update_v_r;

  tag_pkg::tag_packet_s packet_n;
  logic                 id_known;

  // Packet as it stands after this cycle's bit
  always_comb
    begin
      packet_n = {shift_r[$bits(tag_pkg::tag_packet_s)-2:0], tag_data_i};
      id_known = 1'b0;
      for (int i = 0; i < tag_pkg::num_clients_lp; i++)
        begin
          if (packet_n.id == tag_pkg::client_ids_lp[i])
            begin
              id_known = 1'b1;
            end
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          state_r    <= e_idle;
          cnt_r      <= '0;
          update_v_r <= 1'b0;
        end
      else
        begin
          update_v_r <= 1'b0;
          case (state_r)
            e_idle:
              if (tag_data_i)
                begin
                  state_r <= e_recv;
                  cnt_r   <= tag_pkg::body_cnt_lp;
                end
            e_recv:
              begin
                cnt_r <= cnt_r - 1'b1;
                if (cnt_r == tag_pkg::bit_cnt_t'(1))
                  begin
                    state_r    <= e_idle;
                    // Unknown ids are dropped here
                    update_v_r <= id_known;
                  end
              end
            default:
              state_r <= e_idle;
          endcase
        end
    end

  // Shifter holds the last packet until the next start bit
  always_ff @(posedge clk_i)
    begin
      if (state_r == e_recv)
        begin
          shift_r <= packet_n;
        end
    end

  assign update_v_o = update_v_r;
  assign update_o   = shift_r;

endmodule

`default_nettype wire

//--- hw/tag_client_bank.sv
`default_nettype none

module tag_client_bank
  (input  logic                            clk_i
  ,input  logic                            rst_n_i
  ,input  logic                            update_v_i
  ,input  tag_pkg::tag_packet_s            update_i
  ,input  logic                            done_i
  ,output logic                            core_reset_o
  ,output logic                            host_reset_o
  ,output logic                            router_reset_o
  ,output logic [tag_pkg::did_width_lp-1:0] core_did_o
  ,output logic [tag_pkg::did_width_lp-1:0] host_did_o
  ,output logic [tag_pkg::did_width_lp-1:0] router_did_o
  );

  tag_pkg::tag_payload_s payload_r [tag_pkg::num_clients_lp];

  // One register per client, selected by id
  always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        begin
          for (int i = 0; i < tag_pkg::num_clients_lp; i++)
            begin
              payload_r[i] <= '0;
            end
        end
      else if (update_v_i)
        begin
          for (int i = 0; i < tag_pkg::num_clients_lp; i++)
            begin
              if (update_i.id == tag_pkg::client_ids_lp[i])
                begin
                  payload_r[i] <= update_i.payload;
                end
            end
        end
    end

  // Clients stay in reset until the trace has finished
  assign core_reset_o   = payload_r[0].reset | ~done_i;
  assign host_reset_o   = payload_r[1].reset | ~done_i;
  assign router_reset_o = payload_r[2].reset | ~done_i;

  assign core_did_o   = payload_r[0].did;
  assign host_did_o   = payload_r[1].did;
  assign router_did_o = payload_r[2].did;

endmodule

`default_nettype wire

//--- hw/tag_gateway_top.sv
`default_nettype none

module tag_gateway_top
  (input  logic                            clk_i
  ,input  logic                            rst_n_i
  ,input  logic                            enable_i
  ,output logic                            core_reset_o
  ,output logic                            host_reset_o
  ,output logic                            router_reset_o
  ,output logic [tag_pkg::did_width_lp-1:0] core_did_o
  ,output logic [tag_pkg::did_width_lp-1:0] host_did_o
  ,output logic [tag_pkg::did_width_lp-1:0] router_did_o
  ,output logic                            trace_done_o
  );

  logic [tag_pkg::rom_addr_width_lp-1:0] rom_addr_lo;
  tag_pkg::tag_trace_word_s              rom_data_lo;

  logic                 send_v_lo;
  tag_pkg::tag_packet_s send_lo;
  logic                 busy_lo;
  logic                 tag_data_lo;
  logic                 update_v_lo;
  tag_pkg::tag_packet_s update_lo;
  logic                 done_lo;

  //////////////////////////////////////////////////
  // Trace ROM and replay

  tag_trace_rom
    rom
      (.clk_i  ( clk_i )
      ,.addr_i ( rom_addr_lo )
      ,.data_o ( rom_data_lo )
      );

  tag_trace_replay
    replay
      (.clk_i      ( clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.enable_i   ( enable_i )
      ,.rom_addr_o ( rom_addr_lo )
      ,.rom_data_i ( rom_data_lo )
      ,.busy_i     ( busy_lo )
      ,.send_v_o   ( send_v_lo )
      ,.send_o     ( send_lo )
      ,.done_o     ( done_lo )
      );

  //////////////////////////////////////////////////
  // Serial tag link

  tag_serializer
    serializer
      (.clk_i      ( clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.send_v_i   ( send_v_lo )
      ,.send_i     ( send_lo )
      ,.busy_o     ( busy_lo )
      ,.tag_data_o ( tag_data_lo )
      );

  tag_master
    master
      (.clk_i      ( clk_i )
      ,.rst_n_i    ( rst_n_i )
      ,.tag_data_i ( tag_data_lo )
      ,.update_v_o ( update_v_lo )
      ,.update_o   ( update_lo )
      );

  //////////////////////////////////////////////////
  // Client payloads

  tag_client_bank
    client_bank
      (.clk_i          ( clk_i )
      ,.rst_n_i        ( rst_n_i )
      ,.update_v_i     ( update_v_lo )
      ,.update_i       ( update_lo )
      ,.done_i         ( done_lo )
      ,.core_reset_o   ( core_reset_o )
      ,.host_reset_o   ( host_reset_o )
      ,.router_reset_o ( router_reset_o )
      ,.core_did_o     ( core_did_o )
      ,.host_did_o     ( host_did_o )
      ,.router_did_o   ( router_did_o )
      );

  assign trace_done_o = done_lo;

endmodule

`default_nettype wire

//--- test/tb_tag_gateway.sv
`default_nettype none

module tb_tag_gateway;

  typedef logic [tag_pkg::did_width_lp-1:0] did_t;

  localparam int num_entries_lp    = 8;
  // Cycles spent in the two wait words of the trace
  localparam int wait_total_lp     = 36;
  localparam int timeout_cycles_lp = 2 * 4 * (15 * num_entries_lp + wait_total_lp);

  logic clk_i;
  logic rst_n_i;
  logic enable_i;
  logic core_reset_o;
  logic host_reset_o;
  logic router_reset_o;
  did_t core_did_o;
  did_t host_did_o;
  did_t router_did_o;
  logic trace_done_o;

  tag_pkg::tag_packet_s exp_table [num_entries_lp];
  did_t                 prev_did [3];
  did_t                 cur_did [3];

  integer seed      = 32'h3b19_11d0;
  integer rand_val;
  int     cycle_cnt = 0;
  logic   done_seen = 1'b0;
  int     changed;
  did_t   got_did;

  tag_gateway_top
    dut_i
      (.clk_i          ( clk_i )
      ,.rst_n_i        ( rst_n_i )
      ,.enable_i       ( enable_i )
      ,.core_reset_o   ( core_reset_o )
      ,.host_reset_o   ( host_reset_o )
      ,.router_reset_o ( router_reset_o )
      ,.core_did_o     ( core_did_o )
      ,.host_did_o     ( host_did_o )
      ,.router_did_o   ( router_did_o )
      ,.trace_done_o   ( trace_done_o )
      );

  //////////////////////////////////////////////////
  // Reporting and lookup helpers

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("FAILED at time %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // 0 core, 1 host, 2 router, -1 for an id that no client owns
  function automatic int client_index(input logic [tag_pkg::client_id_width_lp-1:0] id);
    if (id == tag_pkg::client_core_lp)
      return 0;
    if (id == tag_pkg::client_host_lp)
      return 1;
    if (id == tag_pkg::client_router_lp)
      return 2;
    return -1;
  endfunction

  function automatic string did_name(input int c);
    return (c == 0) ? "core_did_o" : (c == 1) ? "host_did_o" : "router_did_o";
  endfunction

  function automatic string reset_name(input int c);
    return (c == 0) ? "core_reset_o" : (c == 1) ? "host_reset_o" : "router_reset_o";
  endfunction

  function automatic logic reset_out(input int c);
    return (c == 0) ? core_reset_o : (c == 1) ? host_reset_o : router_reset_o;
  endfunction

  function automatic int last_entry(input int c);
    int last;
    last = -1;
    for (int i = 0; i < num_entries_lp; i++)
      begin
        if (client_index(exp_table[i].id) == c)
          last = i;
      end
    return last;
  endfunction

  //////////////////////////////////////////////////
  // Expected updates in trace order

  task automatic add_entry(input int idx, input logic [3:0] id, input logic rst,
                           input did_t did);
    exp_table[idx].id            = id;
    exp_table[idx].payload.reset = rst;
    exp_table[idx].payload.did   = did;
  endtask

  task automatic load_expected_table();
    add_entry(0, tag_pkg::client_core_lp,   1'b1, 7'h05);
    add_entry(1, tag_pkg::client_host_lp,   1'b1, 7'h12);
    add_entry(2, tag_pkg::client_router_lp, 1'b1, 7'h21);
    // Nobody owns id 3
    add_entry(3, 4'd3,                      1'b0, 7'h7f);
    add_entry(4, tag_pkg::client_core_lp,   1'b0, 7'h0a);
    add_entry(5, tag_pkg::client_host_lp,   1'b1, 7'h33);
    add_entry(6, tag_pkg::client_router_lp, 1'b0, 7'h44);
    add_entry(7, tag_pkg::client_host_lp,   1'b0, 7'h35);
  endtask

  //////////////////////////////////////////////////
  // Output sampling, done on the falling edge

  task automatic sample_dids();
    cur_did[0] = core_did_o;
    cur_did[1] = host_did_o;
    cur_did[2] = router_did_o;
  endtask

  task automatic wait_did_change(output int client, output did_t value);
    int n_changed;
    client = -1;
    value  = '0;
    while (client < 0)
      begin
        @(negedge clk_i);
        sample_dids();
        n_changed = 0;
        for (int c = 0; c < 3; c++)
          begin
            if (cur_did[c] !== prev_did[c])
              begin
                n_changed++;
                client      = c;
                value       = cur_did[c];
                prev_did[c] = cur_did[c];
              end
          end
        assert (n_changed <= 1)
        else report_error("more than one destination id changed in the same cycle");
      end
  endtask

  task automatic check_no_change();
    sample_dids();
    for (int c = 0; c < 3; c++)
      begin
        assert (cur_did[c] === prev_did[c])
        else report_mismatch(did_name(c), cur_did[c], prev_did[c]);
      end
  endtask

  task automatic check_idle_outputs();
    sample_dids();
    for (int c = 0; c < 3; c++)
      begin
        assert (cur_did[c] === '0)
        else report_mismatch(did_name(c), cur_did[c], 0);
        prev_did[c] = cur_did[c];
      end
    assert (trace_done_o === 1'b0)
    else report_mismatch("trace_done_o", trace_done_o, 0);
  endtask

  task automatic check_final_outputs();
    int e;
    sample_dids();
    for (int c = 0; c < 3; c++)
      begin
        e = last_entry(c);
        assert (reset_out(c) === exp_table[e].payload.reset)
        else report_mismatch(reset_name(c), reset_out(c), exp_table[e].payload.reset);
        assert (cur_did[c] === exp_table[e].payload.did)
        else report_mismatch(did_name(c), cur_did[c], exp_table[e].payload.did);
      end
  endtask

  //////////////////////////////////////////////////
  // Clock, enable and timeout

  initial
    begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
    end

  // Enable high on about 3 of 4 cycles
  always @(posedge clk_i)
    begin
      #1;
      rand_val = $random(seed);
      enable_i <= (rand_val[1:0] != 2'b00);
    end

  always @(posedge clk_i)
    begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles_lp)
        begin
          $display("Timeout after %0d cycles, the trace did not finish", cycle_cnt);
          $display(">>> FAIL");
          $fatal(1);
        end
    end

  // Resets held until done, and done never drops once set
  always @(negedge clk_i)
    begin
      if (rst_n_i)
        begin
          if (done_seen)
            assert (trace_done_o === 1'b1)
            else report_mismatch("trace_done_o", trace_done_o, 1);
          if (trace_done_o !== 1'b1)
            begin
              for (int c = 0; c < 3; c++)
                begin
                  assert (reset_out(c) === 1'b1)
                  else report_mismatch(reset_name(c), reset_out(c), 1);
                end
            end
          else
            done_seen = 1'b1;
        end
    end

  //////////////////////////////////////////////////
  // Main sequence

  initial
    begin
      rst_n_i  = 1'b0;
      enable_i = 1'b0;
      load_expected_table();
      repeat (4) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;

      repeat (3)
        begin
          @(negedge clk_i);
          check_idle_outputs();
        end

      // Updates arrive in trace order and unknown ids are skipped
      for (int i = 0; i < num_entries_lp; i++)
        begin
          if (client_index(exp_table[i].id) >= 0)
            begin
              wait_did_change(changed, got_did);
              assert (changed == client_index(exp_table[i].id))
              else report_mismatch("updated client index", changed,
                                   client_index(exp_table[i].id));
              assert (got_did === exp_table[i].payload.did)
              else report_mismatch(did_name(changed), got_did, exp_table[i].payload.did);
            end
        end

      while (trace_done_o !== 1'b1)
        @(negedge clk_i);

      repeat (16)
        begin
          @(negedge clk_i);
          check_no_change();
        end
      check_final_outputs();

      $display(">>> PASS");
      $finish;
    end

endmodule

`default_nettype wire

//--- tag_gateway.f
hw/tag_pkg.sv
hw/tag_trace_rom.sv
hw/tag_trace_replay.sv
hw/tag_serializer.sv
hw/tag_master.sv
hw/tag_client_bank.sv
hw/tag_gateway_top.sv
test/tb_tag_gateway.sv

//--- hw/tag_trace.mem
// Each word is op[13:12] id[11:8] reset[7] did[6:0] in four hex digits
// Op 0 is nop, 1 send, 2 wait and 3 done, and a wait payload is its cycle count
1985  // core reset 1 did 05
1a92  // host reset 1 did 12
1ba1  // router reset 1 did 21
137f  // unknown id 3
2014  // wait 20 cycles
190a  // core reset 0 did 0a
1ab3  // host reset 1 did 33
1b44  // router reset 0 did 44
0000  // nop
1a35  // host reset 0 did 35, last reset cleared
2010  // wait 16 cycles for the last update to land
3000  // done
